//--- agu.sv
`default_nettype none
`timescale 1ns/1ps

module agu import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  issue_t    issue,
    output logic      issue_ready,
    input  logic      lsu_ready,
    output logic      ex_valid,
    output ex_to_ls_t ex,
    input  logic      wb_done,
    input  reg_idx_t  wb_rd,
    output reg_idx_t  rs1_idx,
    output reg_idx_t  rs2_idx,
    input  word_t     rs1_data,
    input  word_t     rs2_data
);
    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] busy_set;
    logic [NUM_REGS-1:0] busy_clr;
    logic                run;
    logic                hazard;
    logic                ex_stall;
    logic                accept;
    logic                wr_en;
    logic                ls_we; // write-enable of the record now in the lsu.
    word_t               sum;

    assign rs1_idx = issue.rs1;
    assign rs2_idx = issue.rs2;

    // any pending write to a register this instruction touches.
    assign hazard   = busy[issue.rs1] | busy[issue.rs2] | busy[issue.rd];
    assign ex_stall = ex_valid & ~lsu_ready; // ex slot full and not draining.

    assign issue_ready = run & ~hazard & ~ex_stall;
    assign accept      = issue_valid & issue_ready;

    assign sum   = rs1_data + issue.imm;
    assign wr_en = (issue.op == OP_ALU || issue.op == OP_LOAD) && issue.rd != '0;

    always_comb begin
        busy_set = '0;
        busy_clr = '0;
        if (accept && wr_en) begin
            busy_set[issue.rd] = 1'b1;
        end
        // only a writer releases its scoreboard bit.
        if (wb_done && ls_we) begin
            busy_clr[wb_rd] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run      <= 1'b0;
            busy     <= '0;
            ex_valid <= 1'b0;
            ls_we    <= 1'b0;
        end else begin
            run  <= 1'b1;
            busy <= (busy & ~busy_clr) | busy_set;
            if (accept) begin
                ex_valid <= 1'b1;
            end else if (lsu_ready) begin
                ex_valid <= 1'b0;
            end
            if (ex_valid && lsu_ready) begin
                ls_we <= ex.we; // record moves into the lsu.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex.op   <= issue.op;
            ex.size <= issue.size;
            ex.sext <= issue.sext;
            ex.rd   <= issue.rd;
            ex.we   <= wr_en;
            ex.addr <= sum;
            ex.data <= (issue.op == OP_STORE) ? rs2_data : sum; // alu result is the sum.
        end
    end

    // ************************************************************
    // checks
    // ************************************************************

    a_aligned: assert property (
        @(posedge clk) disable iff (rst)
        accept && issue.op != OP_ALU |->
            !(issue.size == SZ_HALF && sum[0]) &&
            !(issue.size == SZ_WORD && sum[1:0] != 2'b00)
    ) else $error("agu: misaligned access at %h", sum);

endmodule

`default_nettype wire

//--- lsu.sv
`default_nettype none
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ex_valid,
    input  ex_to_ls_t  ex,
    output logic       lsu_ready,
    output logic       ls_valid,
    output ls_to_wb_t  ls,

    output logic       awvalid,
    input  logic       awready,
    output word_t      awaddr,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       wvalid,
    input  logic       wready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp,

    output logic       arvalid,
    input  logic       arready,
    output word_t      araddr,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    input  logic       rvalid,
    output logic       rready,
    input  logic [1:0] rresp,
    input  word_t      rdata,
    input  logic       rlast
);
    lsu_state_e state;
    logic       take;
    logic       is_sdram;
    logic [1:0] burst;
    logic [1:0] off;
    word_t      st_data;
    strb_t      st_strb;
    word_t      ld_shift;
    word_t      ld_data;
    logic       ar_pend;
    logic       aw_pend;
    logic       w_pend;
    logic       fire;
    logic       resp_ok;

    // request kept for the response phase.
    mem_op_e    req_op;
    mem_size_e  req_size;
    logic       req_sext;
    reg_idx_t   req_rd;
    logic       req_we;
    logic [1:0] req_off;

    assign lsu_ready = (state == LS_IDLE);
    assign take      = ex_valid & lsu_ready;

    assign is_sdram = (ex.addr[31:28] == SDRAM_REGION_LO) || (ex.addr[31:28] == SDRAM_REGION_HI);
    assign burst    = is_sdram ? AXI_BURST_INCR : AXI_BURST_FIXED;
    assign off      = ex.addr[1:0];

    // ************************************************************
    // store lane placement
    // ************************************************************

    assign st_data = ex.data << {off, 3'b000};

    always_comb begin
        case (ex.size)
            SZ_BYTE: st_strb = 4'b0001 << off;
            SZ_HALF: st_strb = 4'b0011 << off;
            default: st_strb = 4'b1111 << off;
        endcase
    end

    assign wlast = wvalid; // single beat writes.

    // ************************************************************
    // load extraction
    // ************************************************************

    assign ld_shift = rdata >> {req_off, 3'b000};

    always_comb begin
        case (req_size)
            SZ_BYTE: ld_data = req_sext ? {{24{ld_shift[7]}}, ld_shift[7:0]}
                                        : {24'b0, ld_shift[7:0]};
            SZ_HALF: ld_data = req_sext ? {{16{ld_shift[15]}}, ld_shift[15:0]}
                                        : {16'b0, ld_shift[15:0]};
            default: ld_data = ld_shift;
        endcase
    end

    // channels still waiting after this edge.
    assign ar_pend = arvalid & ~arready;
    assign aw_pend = awvalid & ~awready;
    assign w_pend  = wvalid & ~wready;

    assign fire    = (rvalid & rready) | (bvalid & bready);
    assign resp_ok = (req_op == OP_LOAD) ? (rresp == AXI_RESP_OKAY) : (bresp == AXI_RESP_OKAY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= LS_IDLE;
            ls_valid <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            arvalid  <= 1'b0;
            bready   <= 1'b0;
            rready   <= 1'b0;
        end else begin
            ls_valid <= 1'b0;
            case (state)
                LS_IDLE: begin
                    if (take) begin
                        case (ex.op)
                            OP_LOAD: begin
                                arvalid <= 1'b1;
                                state   <= LS_ADDR;
                            end
                            OP_STORE: begin
                                awvalid <= 1'b1; // aw and w go out together.
                                wvalid  <= 1'b1;
                                state   <= LS_ADDR;
                            end
                            default: ls_valid <= 1'b1; // alu result passes through.
                        endcase
                    end
                end
                LS_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (!ar_pend && !aw_pend && !w_pend) begin
                        state  <= LS_RESP;
                        rready <= (req_op == OP_LOAD);
                        bready <= (req_op == OP_STORE);
                    end
                end
                LS_RESP: begin
                    if (fire) begin
                        rready   <= 1'b0;
                        bready   <= 1'b0;
                        ls_valid <= 1'b1;
                        state    <= LS_IDLE;
                    end
                end
                default: state <= LS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_op   <= ex.op;
            req_size <= ex.size;
            req_sext <= ex.sext;
            req_rd   <= ex.rd;
            req_we   <= ex.we;
            req_off  <= off;
            araddr   <= ex.addr;
            arsize   <= {1'b0, ex.size};
            arburst  <= burst;
            awaddr   <= ex.addr;
            awsize   <= {1'b0, ex.size};
            awburst  <= burst;
            wdata    <= st_data;
            wstrb    <= st_strb;
            if (ex.op == OP_ALU) begin
                ls.rd   <= ex.rd;
                ls.we   <= ex.we;
                ls.err  <= 1'b0;
                ls.data <= ex.data;
            end
        end
        if (state == LS_RESP && fire) begin
            ls.rd   <= req_rd;
            ls.we   <= req_we & resp_ok; // error keeps rd untouched.
            ls.err  <= ~resp_ok;
            ls.data <= (req_op == OP_LOAD) ? ld_data : '0;
        end
    end

    // ************************************************************
    // checks
    // ************************************************************

    // a memory access blocks new requests until it retires.
    a_one_req: assert property (
        @(posedge clk) disable iff (rst)
        take && ex.op != OP_ALU |=> !lsu_ready until ls_valid
    ) else $error("lsu: new request taken while busy");

    a_wstrb: assert property (
        @(posedge clk) disable iff (rst)
        wvalid |-> wstrb != '0
    ) else $error("lsu: empty write strobe");

    a_rlast: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && rready |-> rlast
    ) else $error("lsu: read beat without rlast");

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ************************************************************
    // machine sizes and address map
    // ************************************************************

    localparam int NUM_REGS = 16; // rv32e register file.

    // sdram window a000_0000 .. bfff_ffff, matched on addr[31:28].
    localparam logic [3:0] SDRAM_REGION_LO = 4'hA;
    localparam logic [3:0] SDRAM_REGION_HI = 4'hB;

    localparam logic [1:0] AXI_BURST_FIXED = 2'd0;
    localparam logic [1:0] AXI_BURST_INCR  = 2'd1;
    localparam logic [1:0] AXI_RESP_OKAY   = 2'd0;

    typedef logic [31:0]                 word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [3:0]                  strb_t;

    // ************************************************************
    // encodings
    // ************************************************************

    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_e;

    // value doubles as axi size.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        LS_IDLE = 2'd0,
        LS_ADDR = 2'd1,
        LS_RESP = 2'd2
    } lsu_state_e;

    // ************************************************************
    // stage records
    // ************************************************************

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        logic      sext; // sign extend on load.
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
    } issue_t;

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        logic      sext;
        reg_idx_t  rd;
        logic      we;
        word_t     addr;
        word_t     data; // store data, or the alu result.
    } ex_to_ls_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        logic     err;
        word_t    data;
    } ls_to_wb_t;

endpackage

`default_nettype wire

//--- lsu_subsys.f
lsu_pkg.sv
agu.sv
lsu.sv
wbu.sv
lsu_subsys.sv
tb_axi_mem.sv
tb_lsu_subsys.sv

//--- lsu_subsys.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_subsys import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       issue_valid,
    input  issue_t     issue,
    output logic       issue_ready,

    output logic       awvalid,
    input  logic       awready,
    output word_t      awaddr,
    output logic [2:0] awsize,
    output logic [1:0] awburst,
    output logic       wvalid,
    input  logic       wready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    input  logic       bvalid,
    output logic       bready,
    input  logic [1:0] bresp,
    output logic       arvalid,
    input  logic       arready,
    output word_t      araddr,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    input  logic       rvalid,
    output logic       rready,
    input  logic [1:0] rresp,
    input  word_t      rdata,
    input  logic       rlast,

    output logic       retire_valid,
    output reg_idx_t   retire_rd,
    output logic       retire_we,
    output logic       retire_err,
    output word_t      retire_data
);
    // ************************************************************
    // stage links
    // ************************************************************
    logic      ex_valid;
    ex_to_ls_t ex;
    logic      lsu_ready;
    logic      ls_valid;
    ls_to_wb_t ls;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wb_done;
    reg_idx_t  wb_rd;

    agu agu_i (.*); // issue, scoreboard, address.
    lsu lsu_i (.*); // axi access.
    wbu wbu_i (.*); // register file, retire.

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_axi_mem import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       awvalid,
    output logic       awready,
    input  word_t      awaddr,
    input  logic [2:0] awsize,
    input  logic [1:0] awburst,
    input  logic       wvalid,
    output logic       wready,
    input  word_t      wdata,
    input  strb_t      wstrb,
    input  logic       wlast,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    input  logic       arvalid,
    output logic       arready,
    input  word_t      araddr,
    input  logic [1:0] arburst,
    output logic       rvalid,
    input  logic       rready,
    output logic [1:0] rresp,
    output word_t      rdata,
    output logic       rlast,
    output int         errors
);
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    word_t      mem [1024]; // 4 kb, same words seen from every region.
    int         seed = 67075;
    logic [1:0] aw_cnt;
    logic [1:0] w_cnt;
    logic [1:0] ar_cnt;
    logic       aw_got;
    logic       w_got;
    word_t      wr_addr;
    word_t      wr_data;
    strb_t      wr_strb;

    function automatic logic in_err(input word_t a);
        return a[11:8] == 4'hF;
    endfunction

    function automatic logic [1:0] region_burst(input word_t a);
        return (a[31:28] == 4'hA || a[31:28] == 4'hB) ? AXI_BURST_INCR : AXI_BURST_FIXED;
    endfunction

    function automatic strb_t lane_mask(input logic [2:0] size);
        case (size)
            3'd0:    return 4'b0001;
            3'd1:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    initial errors = 0;

    assign rlast = rvalid; // single beat reads.

    // ************************************************************
    // ready delays and responses
    // ************************************************************

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            aw_cnt  <= '0;
            w_cnt   <= '0;
            ar_cnt  <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= AXI_RESP_OKAY;
            rvalid  <= 1'b0;
            rresp   <= AXI_RESP_OKAY;
            rdata   <= '0;
        end else begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_cnt  <= 2'($random(seed)); // next delay, 0 to 3 cycles.
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
            end else if (!awready) begin
                if (aw_cnt == 0) awready <= 1'b1;
                else aw_cnt <= aw_cnt - 1'b1;
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_cnt   <= 2'($random(seed));
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end else if (!wready) begin
                if (w_cnt == 0) wready <= 1'b1;
                else w_cnt <= w_cnt - 1'b1;
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_cnt  <= 2'($random(seed));
                rvalid  <= 1'b1;
                rdata   <= mem[araddr[11:2]];
                rresp   <= in_err(araddr) ? RESP_SLVERR : AXI_RESP_OKAY;
            end else begin
                if (!arready) begin
                    if (ar_cnt == 0) arready <= 1'b1;
                    else ar_cnt <= ar_cnt - 1'b1;
                end
                if (rvalid && rready) rvalid <= 1'b0;
            end
            // write lands once both address and data are in.
            if (aw_got && w_got && !bvalid) begin
                if (!in_err(wr_addr)) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) mem[wr_addr[11:2]][8*i +: 8] <= wr_data[8*i +: 8];
                    end
                end
                bvalid <= 1'b1;
                bresp  <= in_err(wr_addr) ? RESP_SLVERR : AXI_RESP_OKAY;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // ************************************************************
    // protocol checks
    // ************************************************************

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
        errors++;
        $display("ERROR: awvalid dropped or awaddr changed before awready");
    end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
        errors++;
        $display("ERROR: wvalid dropped or write data changed before wready");
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        errors++;
        $display("ERROR: arvalid dropped or araddr changed before arready");
    end

    a_wstrb: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> wstrb == strb_t'(lane_mask(awsize) << awaddr[1:0]) && wlast)
    else begin
        errors++;
        $display("ERROR wstrb: expected %b actual %b",
                 strb_t'(lane_mask(awsize) << awaddr[1:0]), wstrb);
    end

    a_awburst: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> awburst == region_burst(awaddr))
    else begin
        errors++;
        $display("ERROR awburst: expected %0d actual %0d", region_burst(awaddr), awburst);
    end

    a_arburst: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> arburst == region_burst(araddr))
    else begin
        errors++;
        $display("ERROR arburst: expected %0d actual %0d", region_burst(araddr), arburst);
    end

endmodule

`default_nettype wire

//--- tb_lsu_subsys.sv
`default_nettype none
`timescale 1ns/1ps

module tb_lsu_subsys import lsu_pkg::*; ();
    localparam int N_INSTR    = 400;
    localparam int CLK_PERIOD = 20;
    localparam int WATCHDOG   = (N_INSTR * 200 + 20) * CLK_PERIOD;

    typedef struct packed {
        int       seq;
        mem_op_e  op;
        reg_idx_t rd;
        logic     we;
        logic     err;
        word_t    data;
    } retire_exp_t;

    typedef struct packed {
        word_t     addr;
        mem_size_e size;
        word_t     data;
    } wr_exp_t;

    typedef struct packed {
        word_t     addr;
        mem_size_e size;
    } rd_exp_t;

    logic       clk;
    logic       rst;
    logic       issue_valid;
    issue_t     issue;
    logic       issue_ready;
    logic       awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic       arvalid, arready, rvalid, rready, rlast;
    word_t      awaddr, wdata, araddr, rdata;
    logic [2:0] awsize, arsize;
    logic [1:0] awburst, arburst, bresp, rresp;
    strb_t      wstrb;
    logic       retire_valid, retire_we, retire_err;
    reg_idx_t   retire_rd;
    word_t      retire_data;

    int          seed = 67075;
    int          errors;
    int          mem_errors;
    word_t       shadow_reg [NUM_REGS];
    word_t       shadow_mem [1024];
    retire_exp_t exp_q [$];
    wr_exp_t     wr_q [$];
    rd_exp_t     rd_q [$];

    lsu_subsys lsu_subsys_i (.*);
    tb_axi_mem axi_mem_i (.errors(mem_errors), .*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ************************************************************
    // reference model helpers
    // ************************************************************

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t fill_word(input int idx);
        return word_t'((idx + 1) * 32'h9E37_79B9); // differs for every word index.
    endfunction

    function automatic word_t reg_val(input reg_idx_t idx);
        return (idx == '0) ? '0 : shadow_reg[idx];
    endfunction

    function automatic logic in_err(input word_t a);
        return a[11:8] == 4'hF;
    endfunction

    function automatic strb_t lane_bits(input mem_size_e size);
        case (size)
            SZ_BYTE: return 4'b0001;
            SZ_HALF: return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // few words per bank so stores and loads hit each other often.
    function automatic word_t make_addr(input mem_size_e size);
        logic [3:0] top;
        logic [3:0] bank;
        logic [1:0] off;
        case (pick(4))
            0:       top = 4'hA;
            1:       top = 4'hB;
            2:       top = 4'h0;
            default: top = 4'h3;
        endcase
        bank = (pick(8) == 0) ? 4'hF : 4'(pick(3));
        case (size)
            SZ_BYTE: off = 2'(pick(4));
            SZ_HALF: off = 2'(pick(2) * 2);
            default: off = 2'b00;
        endcase
        return {top, 16'($random(seed)), bank, 2'b00, 4'(pick(16)), off};
    endfunction

    function automatic word_t load_value(input word_t addr, input mem_size_e size,
                                         input logic sext);
        word_t w;
        w = shadow_mem[addr[11:2]] >> (8 * addr[1:0]);
        case (size)
            SZ_BYTE: return sext ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            SZ_HALF: return sext ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic void store_shadow(input word_t addr, input mem_size_e size,
                                         input word_t data);
        strb_t strb;
        word_t lanes;
        strb  = lane_bits(size) << addr[1:0];
        lanes = data << (8 * addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) shadow_mem[addr[11:2]][8*i +: 8] = lanes[8*i +: 8];
        end
    endfunction

    function automatic string name_of(input retire_exp_t e);
        return $sformatf("%s #%0d", e.op.name(), e.seq);
    endfunction

    // builds one instruction and applies it to the shadow state in issue order.
    task automatic make_instr(input int seq, output issue_t ins);
        retire_exp_t e;
        word_t       addr;
        ins.rd   = reg_idx_t'(pick(NUM_REGS));
        ins.rs1  = reg_idx_t'(pick(NUM_REGS));
        ins.rs2  = reg_idx_t'(pick(NUM_REGS));
        ins.sext = logic'(pick(2));
        ins.op   = mem_op_e'(pick(3));
        e.seq = seq;
        e.op  = ins.op;
        e.rd  = ins.rd;
        if (ins.op == OP_ALU) begin
            ins.size = SZ_WORD;
            ins.imm  = (pick(4) == 0) ? '0 : word_t'($random(seed)); // imm 0 reads back rs1.
            e.data   = reg_val(ins.rs1) + ins.imm;
            e.err    = 1'b0;
            e.we     = ins.rd != '0;
        end else begin
            ins.size = mem_size_e'(pick(3));
            addr     = make_addr(ins.size);
            ins.imm  = addr - reg_val(ins.rs1);
            e.err    = in_err(addr);
            if (ins.op == OP_LOAD) begin
                e.we   = ins.rd != '0 && !e.err;
                e.data = load_value(addr, ins.size, ins.sext);
                rd_q.push_back('{addr, ins.size});
            end else begin
                e.we   = 1'b0;
                e.data = '0;
                wr_q.push_back('{addr, ins.size, reg_val(ins.rs2)});
                if (!e.err) store_shadow(addr, ins.size, reg_val(ins.rs2));
            end
        end
        if (e.we) shadow_reg[ins.rd] = e.data;
        exp_q.push_back(e);
    endtask

    // ************************************************************
    // stimulus
    // ************************************************************

    initial begin
        issue_t ins;
        issue_valid = 1'b0;
        issue       = '0;
        rst         = 1'b1;
        errors      = 0;
        for (int i = 0; i < NUM_REGS; i++) shadow_reg[i] = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow_mem[i]       = fill_word(i);
            axi_mem_i.mem[i] = fill_word(i);
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int k = 0; k < N_INSTR; k++) begin
            make_instr(k, ins);
            issue       <= ins;
            issue_valid <= 1'b1;
            @(posedge clk);
            while (!issue_ready) @(posedge clk); // taken at the edge where ready was high.
        end
        issue_valid <= 1'b0;
        while (exp_q.size() != 0 || wr_q.size() != 0 || rd_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk); // late duplicates would show here.
        $display("errors: testbench %0d, memory model %0d", errors, mem_errors);
        if (errors == 0 && mem_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired with %0d retires still outstanding", exp_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

    // ************************************************************
    // checks
    // ************************************************************

    always @(posedge clk) begin
        retire_exp_t e;
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: retire of rd %0d with no instruction outstanding", retire_rd);
            end else begin
                e = exp_q.pop_front();
                assert (retire_rd == e.rd) else begin
                    errors++;
                    $display("ERROR %s rd: expected %0d actual %0d", name_of(e), e.rd, retire_rd);
                end
                assert (retire_we == e.we && retire_err == e.err) else begin
                    errors++;
                    $display("ERROR %s we/err: expected %b/%b actual %b/%b", name_of(e),
                             e.we, e.err, retire_we, retire_err);
                end
                if (e.we) begin
                    assert (retire_data == e.data) else begin
                        errors++;
                        $display("ERROR %s data: expected %h actual %h", name_of(e),
                                 e.data, retire_data);
                    end
                end
            end
        end
    end

    // read address and size follow the load stream.
    always @(posedge clk) begin
        rd_exp_t r;
        if (!rst && arvalid && arready) begin
            if (rd_q.size() == 0) begin
                errors++;
                $display("ERROR: read request with no load outstanding");
            end else begin
                r = rd_q.pop_front();
                assert (araddr == r.addr && arsize == 3'(r.size)) else begin
                    errors++;
                    $display("ERROR load ar: expected %h/%0d actual %h/%0d", r.addr, r.size,
                             araddr, arsize);
                end
            end
        end
    end

    // byte lanes under the strobe carry the store data.
    always @(posedge clk) begin
        wr_exp_t w;
        strb_t   strb;
        word_t   mask;
        word_t   lanes;
        if (!rst && wvalid && wready) begin
            if (wr_q.size() == 0) begin
                errors++;
                $display("ERROR: write beat with no store outstanding");
            end else begin
                w     = wr_q.pop_front();
                strb  = lane_bits(w.size) << w.addr[1:0];
                lanes = w.data << (8 * w.addr[1:0]);
                for (int i = 0; i < 4; i++) mask[8*i +: 8] = {8{strb[i]}};
                assert ((wdata & mask) == (lanes & mask)) else begin
                    errors++;
                    $display("ERROR store to %h wdata: expected %h actual %h", w.addr,
                             lanes & mask, wdata & mask);
                end
                assert (awaddr == w.addr && awsize == 3'(w.size)) else begin
                    errors++;
                    $display("ERROR store aw: expected %h/%0d actual %h/%0d", w.addr, w.size,
                             awaddr, awsize);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- wbu.sv
`default_nettype none
`timescale 1ns/1ps

module wbu import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ls_valid,
    input  ls_to_wb_t ls,
    input  reg_idx_t  rs1_idx,
    input  reg_idx_t  rs2_idx,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output logic      wb_done,
    output reg_idx_t  wb_rd,
    output logic      retire_valid,
    output reg_idx_t  retire_rd,
    output logic      retire_we,
    output logic      retire_err,
    output word_t     retire_data
);
    word_t regs [NUM_REGS];

    // x0 is hardwired to zero.
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // releases the scoreboard entry, also on a faulted access.
    assign wb_done = ls_valid;
    assign wb_rd   = ls.rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ls_valid;
            if (ls_valid && ls.we) begin
                regs[ls.rd] <= ls.data;
            end
        end
    end

    // retire report, one cycle behind the write.
    always_ff @(posedge clk) begin
        if (ls_valid) begin
            retire_rd   <= ls.rd;
            retire_we   <= ls.we;
            retire_err  <= ls.err;
            retire_data <= ls.data;
        end
    end

endmodule

`default_nettype wire
